// File: logic/soc_pkg.sv
package soc_pkg;

	// bus widths
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;
	typedef logic [1:0]  resp_t;

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;
	localparam resp_t RESP_DECERR = 2'b11;

	localparam int GPIO_W  = 22;
	localparam int TMR_W   = 16;
	localparam int SLAVE_N = 2;
	localparam int IRQ_N   = 2;

	typedef logic [GPIO_W-1:0] gpio_vec_t;
	typedef logic [TMR_W-1:0]  tmr_cnt_t;

	// slave slot and irq bit are the same index
	localparam int SLV_GPIO = 0;
	localparam int SLV_TMR  = 1;

	localparam addr_t GPIO_BASE   = 32'h4000_0000;
	localparam addr_t TIMER_BASE  = 32'h4000_2000;
	localparam addr_t SLAVE_RANGE = 32'd4096;

	localparam int OFS_W = 12; // offset bits inside one window

	localparam logic [OFS_W-1:0] GPIO_OUT_OFS   = 12'h000;
	localparam logic [OFS_W-1:0] GPIO_TRI_OFS   = 12'h004; // 1 = input
	localparam logic [OFS_W-1:0] GPIO_IN_OFS    = 12'h008; // read only
	localparam logic [OFS_W-1:0] GPIO_ISTAT_OFS = 12'h00C; // write 1 to clear
	localparam logic [OFS_W-1:0] GPIO_IEN_OFS   = 12'h010;

	localparam logic [OFS_W-1:0] TMR_CTRL_OFS = 12'h000;
	localparam logic [OFS_W-1:0] TMR_LOAD_OFS = 12'h004;
	localparam logic [OFS_W-1:0] TMR_CNT_OFS  = 12'h008; // read only
	localparam logic [OFS_W-1:0] TMR_STAT_OFS = 12'h00C; // write 1 to clear

	typedef struct packed {
		addr_t awaddr;
		logic  awvalid;
		data_t wdata;
		strb_t wstrb;
		logic  wvalid;
		logic  bready;
		addr_t araddr;
		logic  arvalid;
		logic  rready;
	} axil_req_t;

	typedef struct packed {
		logic  awready;
		logic  wready;
		resp_t bresp;
		logic  bvalid;
		logic  arready;
		data_t rdata;
		resp_t rresp;
		logic  rvalid;
	} axil_rsp_t;

	// shared by all slaves with psel picking one
	typedef struct packed {
		addr_t paddr;
		logic  pwrite;
		data_t pwdata;
		strb_t pstrb;
		logic  penable;
	} apb_req_t;

	typedef struct packed {
		data_t prdata;
		logic  pready;
		logic  pslverr;
	} apb_rsp_t;

	typedef enum logic [1:0] {
		IDLE,
		SETUP,
		ACCESS,
		RESP
	} bridge_state_t;

	// byte strobes expanded to a bit mask
	function automatic data_t strb_mask(strb_t strb);
		data_t m;
		for (int i = 0; i < 4; i++)
			m[8*i +: 8] = {8{strb[i]}};
		return m;
	endfunction

endpackage

// File: logic/sys_reset_sync.sv
`timescale 1ns/1ps

module sys_reset_sync (
	input  logic pll_clk_out,
	input  logic arst_n_i,
	output logic sys_rst_n_o
);

	logic meta_q;
	logic sync_q;

	// assert at once and release after two edges
	always_ff @(posedge pll_clk_out or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			meta_q <= 1'b0;
			sync_q <= 1'b0;
		end
		else
		begin
			meta_q <= 1'b1;
			sync_q <= meta_q;
		end
	end

	assign sys_rst_n_o = sync_q;

	a_rst_follows: assert property (@(posedge pll_clk_out)
		!arst_n_i |-> !sys_rst_n_o);

endmodule

// File: logic/axi_apb_bridge.sv
`timescale 1ns/1ps

module axi_apb_bridge import soc_pkg::*; (
	input  logic               pll_clk_out,
	input  logic               rst_n_i,
	input  axil_req_t          axi_req_i,
	output axil_rsp_t          axi_rsp_o,
	output apb_req_t           apb_req_o,
	output logic [SLAVE_N-1:0] psel_o,
	input  apb_rsp_t           apb_rsp0_i,
	input  apb_rsp_t           apb_rsp1_i
);

	bridge_state_t state_q;

	// request held for the whole transfer
	addr_t              addr_q;
	data_t              wdata_q;
	strb_t              strb_q;
	logic               write_q;
	logic [SLAVE_N-1:0] sel_q;

	data_t rdata_q;
	resp_t resp_q;

	logic               rd_acc;
	logic               wr_acc;
	addr_t              req_addr;
	logic [SLAVE_N-1:0] req_sel;
	apb_rsp_t           sel_rsp;
	logic               apb_done;
	logic               rsp_taken;

	function automatic logic in_window(addr_t a, addr_t base);
		return (a >= base) && (a < base + SLAVE_RANGE);
	endfunction

	// read wins over a pending write
	assign rd_acc = (state_q == IDLE) && axi_req_i.arvalid;
	assign wr_acc = (state_q == IDLE) && axi_req_i.awvalid && axi_req_i.wvalid
		&& !axi_req_i.arvalid;

	assign req_addr = rd_acc ? axi_req_i.araddr : axi_req_i.awaddr;

	always_comb
	begin
		req_sel = '0;
		req_sel[SLV_GPIO] = in_window(req_addr, GPIO_BASE);
		req_sel[SLV_TMR]  = in_window(req_addr, TIMER_BASE);
	end

	assign sel_rsp   = sel_q[SLV_TMR] ? apb_rsp1_i : apb_rsp0_i;
	assign apb_done  = (state_q == ACCESS) && sel_rsp.pready;
	assign rsp_taken = write_q ? axi_req_i.bready : axi_req_i.rready;

	always_ff @(posedge pll_clk_out or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state_q <= IDLE;
			write_q <= 1'b0;
			sel_q   <= '0;
		end
		else
		begin
			case (state_q)
				IDLE:
				begin
					if (rd_acc || wr_acc)
					begin
						write_q <= wr_acc;
						sel_q   <= req_sel;
						state_q <= (|req_sel) ? SETUP : RESP; // unmapped skips apb
					end
				end
				SETUP:
					state_q <= ACCESS;
				ACCESS:
				begin
					if (apb_done)
						state_q <= RESP;
				end
				RESP:
				begin
					if (rsp_taken)
						state_q <= IDLE;
				end
				default:
					state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge pll_clk_out)
	begin
		if (rd_acc || wr_acc)
		begin
			addr_q  <= req_addr;
			wdata_q <= axi_req_i.wdata;
			strb_q  <= rd_acc ? '0 : axi_req_i.wstrb; // pstrb low on reads
			rdata_q <= '0;
			resp_q  <= (|req_sel) ? RESP_OKAY : RESP_DECERR;
		end
		else if (apb_done)
		begin
			rdata_q <= sel_rsp.prdata;
			resp_q  <= sel_rsp.pslverr ? RESP_SLVERR : RESP_OKAY;
		end
	end

	assign axi_rsp_o.arready = rd_acc;
	assign axi_rsp_o.awready = wr_acc;
	assign axi_rsp_o.wready  = wr_acc;
	assign axi_rsp_o.bvalid  = (state_q == RESP) && write_q;
	assign axi_rsp_o.bresp   = resp_q;
	assign axi_rsp_o.rvalid  = (state_q == RESP) && !write_q;
	assign axi_rsp_o.rresp   = resp_q;
	assign axi_rsp_o.rdata   = rdata_q;

	assign apb_req_o.paddr   = addr_q;
	assign apb_req_o.pwrite  = write_q;
	assign apb_req_o.pwdata  = wdata_q;
	assign apb_req_o.pstrb   = strb_q;
	assign apb_req_o.penable = (state_q == ACCESS);

	assign psel_o = (state_q == SETUP || state_q == ACCESS) ? sel_q : '0;

	// access always comes after a setup cycle on the same slave
	a_penable_psel: assert property (@(posedge pll_clk_out) disable iff (!rst_n_i)
		apb_req_o.penable |-> (|psel_o) && $past(psel_o) == psel_o);

	a_one_resp: assert property (@(posedge pll_clk_out) disable iff (!rst_n_i)
		!(axi_rsp_o.bvalid && axi_rsp_o.rvalid));

endmodule

// File: logic/apb_gpio.sv
`timescale 1ns/1ps

module apb_gpio import soc_pkg::*; (
	input  logic      pll_clk_out,
	input  logic      rst_n_i,
	input  apb_req_t  apb_req_i,
	input  logic      psel_i,
	output apb_rsp_t  apb_rsp_o,
	input  gpio_vec_t gpio_i,
	output gpio_vec_t gpio_o,
	output gpio_vec_t gpio_t_o,
	output logic      irq_o
);

	gpio_vec_t out_q;
	gpio_vec_t tri_q;
	gpio_vec_t ien_q;
	gpio_vec_t istat_q;
	gpio_vec_t sync1_q;
	gpio_vec_t sync2_q;
	gpio_vec_t prev_q; // last synchronized value

	logic             wr_en;
	logic [OFS_W-1:0] ofs;
	data_t            wmask;
	gpio_vec_t        bmask;
	gpio_vec_t        bdata;
	gpio_vec_t        fall;
	gpio_vec_t        istat_clr;
	data_t            rdata;

	assign ofs   = apb_req_i.paddr[OFS_W-1:0];
	assign wr_en = psel_i && apb_req_i.penable && apb_req_i.pwrite;
	assign wmask = strb_mask(apb_req_i.pstrb);
	assign bmask = wmask[GPIO_W-1:0];
	assign bdata = apb_req_i.pwdata[GPIO_W-1:0];

	always_ff @(posedge pll_clk_out or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			out_q <= '0;
			tri_q <= '1; // all pins start as inputs
			ien_q <= '0;
		end
		else if (wr_en)
		begin
			case (ofs)
				GPIO_OUT_OFS: out_q <= (out_q & ~bmask) | (bdata & bmask);
				GPIO_TRI_OFS: tri_q <= (tri_q & ~bmask) | (bdata & bmask);
				GPIO_IEN_OFS: ien_q <= (ien_q & ~bmask) | (bdata & bmask);
				default: ;
			endcase
		end
	end

	// two flop input synchronizer plus edge history
	always_ff @(posedge pll_clk_out or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			sync1_q <= '0;
			sync2_q <= '0;
			prev_q  <= '0;
		end
		else
		begin
			sync1_q <= gpio_i;
			sync2_q <= sync1_q;
			prev_q  <= sync2_q;
		end
	end

	assign fall      = prev_q & ~sync2_q;
	assign istat_clr = (wr_en && ofs == GPIO_ISTAT_OFS) ? (bdata & bmask) : '0;

	// new edge beats a clear in the same cycle
	always_ff @(posedge pll_clk_out or negedge rst_n_i)
	begin
		if (!rst_n_i)
			istat_q <= '0;
		else
			istat_q <= (istat_q & ~istat_clr) | fall;
	end

	always_comb
	begin
		rdata = '0;
		case (ofs)
			GPIO_OUT_OFS:   rdata = data_t'(out_q);
			GPIO_TRI_OFS:   rdata = data_t'(tri_q);
			GPIO_IN_OFS:    rdata = data_t'(sync2_q);
			GPIO_ISTAT_OFS: rdata = data_t'(istat_q);
			GPIO_IEN_OFS:   rdata = data_t'(ien_q);
			default:        rdata = '0;
		endcase
	end

	assign apb_rsp_o.prdata  = rdata;
	assign apb_rsp_o.pready  = 1'b1; // no wait states
	assign apb_rsp_o.pslverr = 1'b0;

	assign gpio_o   = out_q;
	assign gpio_t_o = tri_q;
	assign irq_o    = |(istat_q & ien_q);

	a_no_wait: assert property (@(posedge pll_clk_out) disable iff (!rst_n_i)
		psel_i |-> apb_rsp_o.pready);

endmodule

// File: logic/apb_timer.sv
`timescale 1ns/1ps

module apb_timer import soc_pkg::*; (
	input  logic     pll_clk_out,
	input  logic     rst_n_i,
	input  apb_req_t apb_req_i,
	input  logic     psel_i,
	output apb_rsp_t apb_rsp_o,
	output logic     irq_o
);

	logic     en_q;
	tmr_cnt_t load_q;
	tmr_cnt_t cnt_q;
	logic     flag_q; // sticky expiry

	logic             wr_en;
	logic [OFS_W-1:0] ofs;
	data_t            wmask;
	tmr_cnt_t         new_load;
	logic             ctrl_wr;
	logic             load_wr;
	logic             stat_clr;
	logic             reload;
	data_t            rdata;

	assign ofs   = apb_req_i.paddr[OFS_W-1:0];
	assign wr_en = psel_i && apb_req_i.penable && apb_req_i.pwrite;
	assign wmask = strb_mask(apb_req_i.pstrb);

	assign new_load = (load_q & ~wmask[TMR_W-1:0])
		| (apb_req_i.pwdata[TMR_W-1:0] & wmask[TMR_W-1:0]);

	assign ctrl_wr  = wr_en && ofs == TMR_CTRL_OFS && apb_req_i.pstrb[0];
	assign load_wr  = wr_en && ofs == TMR_LOAD_OFS;
	assign stat_clr = wr_en && ofs == TMR_STAT_OFS && (apb_req_i.pwdata[0] & wmask[0]);
	assign reload   = en_q && cnt_q == '0;

	always_ff @(posedge pll_clk_out or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			en_q   <= 1'b0;
			load_q <= '0;
			cnt_q  <= '0;
			flag_q <= 1'b0;
		end
		else
		begin
			if (ctrl_wr)
				en_q <= apb_req_i.pwdata[0];
			if (load_wr)
				load_q <= new_load;

			if (reload)
				cnt_q <= load_q; // step after zero
			else if (en_q)
				cnt_q <= cnt_q - tmr_cnt_t'(1);
			else if (load_wr)
				cnt_q <= new_load; // preset while stopped

			if (reload)
				flag_q <= 1'b1;
			else if (stat_clr)
				flag_q <= 1'b0;
		end
	end

	always_comb
	begin
		rdata = '0;
		case (ofs)
			TMR_CTRL_OFS: rdata = data_t'(en_q);
			TMR_LOAD_OFS: rdata = data_t'(load_q);
			TMR_CNT_OFS:  rdata = data_t'(cnt_q);
			TMR_STAT_OFS: rdata = data_t'(flag_q);
			default:      rdata = '0;
		endcase
	end

	assign apb_rsp_o.prdata  = rdata;
	assign apb_rsp_o.pready  = 1'b1;
	assign apb_rsp_o.pslverr = 1'b0;

	assign irq_o = flag_q;

	// running count stays inside the reload range
	a_cnt_range: assert property (@(posedge pll_clk_out) disable iff (!rst_n_i)
		en_q && !load_wr && cnt_q <= load_q |=> cnt_q <= load_q);

endmodule

// File: logic/periph_soc_top.sv
`timescale 1ns/1ps

module periph_soc_top import soc_pkg::*; (
	input  logic             pll_clk_out,
	input  logic             arst_n_i,
	input  axil_req_t        s_axi_req_i,
	output axil_rsp_t        s_axi_rsp_o,
	input  gpio_vec_t        gpio_i,
	output gpio_vec_t        gpio_o,
	output gpio_vec_t        gpio_t_o,
	output logic [IRQ_N-1:0] irq_o
);

	logic               sys_rst_n;
	apb_req_t           apb_req;
	logic [SLAVE_N-1:0] psel;
	apb_rsp_t           gpio_rsp;
	apb_rsp_t           tmr_rsp;

	sys_reset_sync u_rst_sync (
		.pll_clk_out (pll_clk_out),
		.arst_n_i    (arst_n_i),
		.sys_rst_n_o (sys_rst_n)
	);

	axi_apb_bridge u_bridge (
		.pll_clk_out (pll_clk_out),
		.rst_n_i     (sys_rst_n),
		.axi_req_i   (s_axi_req_i),
		.axi_rsp_o   (s_axi_rsp_o),
		.apb_req_o   (apb_req),
		.psel_o      (psel),
		.apb_rsp0_i  (gpio_rsp),
		.apb_rsp1_i  (tmr_rsp)
	);

	apb_gpio u_gpio (
		.pll_clk_out (pll_clk_out),
		.rst_n_i     (sys_rst_n),
		.apb_req_i   (apb_req),
		.psel_i      (psel[SLV_GPIO]),
		.apb_rsp_o   (gpio_rsp),
		.gpio_i      (gpio_i),
		.gpio_o      (gpio_o),
		.gpio_t_o    (gpio_t_o),
		.irq_o       (irq_o[SLV_GPIO])
	);

	apb_timer u_timer (
		.pll_clk_out (pll_clk_out),
		.rst_n_i     (sys_rst_n),
		.apb_req_i   (apb_req),
		.psel_i      (psel[SLV_TMR]),
		.apb_rsp_o   (tmr_rsp),
		.irq_o       (irq_o[SLV_TMR])
	);

endmodule

// File: verification/tb_bus_tasks.svh
// register model mirroring every DUT register
gpio_vec_t m_out   = '0;
gpio_vec_t m_tri   = '1; // pins start as inputs
gpio_vec_t m_ien   = '0;
gpio_vec_t m_istat = '0;
gpio_vec_t m_in    = '0; // pattern on gpio_i
logic      t_en    = 1'b0;
tmr_cnt_t  t_load  = '0;
tmr_cnt_t  t_cnt   = '0; // only valid while stopped
logic      t_flag  = 1'b0;

logic [31:0] lfsr_q = 32'd14;

// galois lfsr stepped once per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
	begin
		v = {v[30:0], lfsr_q[0]};
		lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
	end
	return v;
endfunction

function automatic data_t merge_bytes(input data_t old, input data_t d, input strb_t s);
	data_t v;
	v = old;
	for (int b = 0; b < 4; b++)
	begin
		if (s[b])
			v[8*b +: 8] = d[8*b +: 8];
	end
	return v;
endfunction

function automatic void model_write(input addr_t a, input data_t d, input strb_t s);
	case (a)
		A_OUT:   m_out = gpio_vec_t'(merge_bytes(data_t'(m_out), d, s));
		A_TRI:   m_tri = gpio_vec_t'(merge_bytes(data_t'(m_tri), d, s));
		A_IEN:   m_ien = gpio_vec_t'(merge_bytes(data_t'(m_ien), d, s));
		A_ISTAT: m_istat = m_istat & ~gpio_vec_t'(merge_bytes('0, d, s)); // write 1 clears
		A_CTRL:
		begin
			if (s[0])
				t_en = d[0];
		end
		A_LOAD:
		begin
			t_load = tmr_cnt_t'(merge_bytes(data_t'(t_load), d, s));
			if (!t_en)
				t_cnt = t_load; // preset while stopped
		end
		A_STAT:
		begin
			if (s[0] && d[0])
				t_flag = 1'b0;
		end
		default: ;
	endcase
endfunction

function automatic data_t model_read(input addr_t a);
	case (a)
		A_OUT:   return data_t'(m_out);
		A_TRI:   return data_t'(m_tri);
		A_IN:    return data_t'(m_in);
		A_ISTAT: return data_t'(m_istat);
		A_IEN:   return data_t'(m_ien);
		A_CTRL:  return data_t'(t_en);
		A_LOAD:  return data_t'(t_load);
		A_CNT:   return data_t'(t_cnt);
		A_STAT:  return data_t'(t_flag);
		default: return '0;
	endcase
endfunction

function automatic logic [IRQ_N-1:0] exp_irq();
	logic [IRQ_N-1:0] v;
	v[SLV_GPIO] = |(m_istat & m_ien);
	v[SLV_TMR]  = t_flag;
	return v;
endfunction

// keeps the response waiting and offers a competing read meanwhile
task automatic hold_response(input logic is_wr, input int cycles);
	resp_t r0;
	data_t d0;
	r0 = is_wr ? rsp.bresp : rsp.rresp;
	d0 = rsp.rdata;
	for (int i = 0; i < cycles; i++)
	begin
		@(negedge pll_clk_out);
		req.araddr  = A_IN;
		req.arvalid = 1'b1;
		#1;
		if (is_wr)
		begin
			compare("bvalid", 32'd1, data_t'(rsp.bvalid));
			compare("bresp", data_t'(r0), data_t'(rsp.bresp));
		end
		else
		begin
			compare("rvalid", 32'd1, data_t'(rsp.rvalid));
			compare("rresp", data_t'(r0), data_t'(rsp.rresp));
			compare("rdata", d0, rsp.rdata);
		end
		compare("arready", 32'd0, data_t'(rsp.arready)); // bridge still busy
	end
	@(negedge pll_clk_out);
	req.arvalid = 1'b0;
	if (is_wr)
		req.bready = 1'b1;
	else
		req.rready = 1'b1;
	@(negedge pll_clk_out);
	req.bready = 1'b0;
	req.rready = 1'b0;
endtask

task automatic axi_write(input addr_t a, input data_t d, input strb_t s, input int hold,
	output resp_t r);
	@(negedge pll_clk_out);
	req.awaddr  = a;
	req.wdata   = d;
	req.wstrb   = s;
	req.awvalid = 1'b1;
	req.wvalid  = 1'b1;
	#1;
	while (!(rsp.awready && rsp.wready))
	begin
		@(negedge pll_clk_out);
		#1;
	end
	@(negedge pll_clk_out); // accepted on the edge just passed
	req.awvalid = 1'b0;
	req.wvalid  = 1'b0;
	#1;
	while (!rsp.bvalid)
	begin
		@(negedge pll_clk_out);
		#1;
	end
	r = rsp.bresp;
	hold_response(1'b1, hold);
endtask

task automatic axi_read(input addr_t a, input int hold, output data_t d, output resp_t r);
	@(negedge pll_clk_out);
	req.araddr  = a;
	req.arvalid = 1'b1;
	#1;
	while (!rsp.arready)
	begin
		@(negedge pll_clk_out);
		#1;
	end
	@(negedge pll_clk_out);
	req.arvalid = 1'b0;
	#1;
	while (!rsp.rvalid)
	begin
		@(negedge pll_clk_out);
		#1;
	end
	d = rsp.rdata;
	r = rsp.rresp;
	hold_response(1'b0, hold);
endtask

// File: verification/tb_periph_soc.sv
`timescale 1ns/1ps

module tb_periph_soc import soc_pkg::*; ();

	localparam addr_t A_OUT   = GPIO_BASE + addr_t'(GPIO_OUT_OFS);
	localparam addr_t A_TRI   = GPIO_BASE + addr_t'(GPIO_TRI_OFS);
	localparam addr_t A_IN    = GPIO_BASE + addr_t'(GPIO_IN_OFS);
	localparam addr_t A_ISTAT = GPIO_BASE + addr_t'(GPIO_ISTAT_OFS);
	localparam addr_t A_IEN   = GPIO_BASE + addr_t'(GPIO_IEN_OFS);
	localparam addr_t A_CTRL  = TIMER_BASE + addr_t'(TMR_CTRL_OFS);
	localparam addr_t A_LOAD  = TIMER_BASE + addr_t'(TMR_LOAD_OFS);
	localparam addr_t A_CNT   = TIMER_BASE + addr_t'(TMR_CNT_OFS);
	localparam addr_t A_STAT  = TIMER_BASE + addr_t'(TMR_STAT_OFS);

	localparam int N_REGS = 9;
	localparam addr_t REG_LIST [N_REGS] = '{A_OUT, A_TRI, A_IN, A_ISTAT, A_IEN,
		A_CTRL, A_LOAD, A_CNT, A_STAT};

	localparam int N_GPIO_WR = 60;
	localparam int N_GPIO_IN = 40;
	localparam int N_PERIODS = 4;
	localparam int N_UNMAP   = 12;

	// all transfers of the run take under 10 cycles each even with a hold of 3
	localparam int N_XFERS = 3 * N_REGS + 2 * N_GPIO_WR + 5 * N_GPIO_IN + 3 * N_PERIODS
		+ 2 * N_UNMAP + 10;
	localparam int TIMEOUT_CYC = 4 * (10 * N_XFERS + 4 * N_GPIO_IN + 40 * N_PERIODS);

	logic             pll_clk_out = 1'b0;
	logic             arst_n_i;
	axil_req_t        req;
	axil_rsp_t        rsp;
	gpio_vec_t        gpio_i;
	gpio_vec_t        gpio_o;
	gpio_vec_t        gpio_t_o;
	logic [IRQ_N-1:0] irq_o;

	int cyc      = 0;
	int n_checks = 0;
	int n_errors = 0;

	always #2 pll_clk_out = ~pll_clk_out;

	periph_soc_top u_dut (
		.pll_clk_out (pll_clk_out),
		.arst_n_i    (arst_n_i),
		.s_axi_req_i (req),
		.s_axi_rsp_o (rsp),
		.gpio_i      (gpio_i),
		.gpio_o      (gpio_o),
		.gpio_t_o    (gpio_t_o),
		.irq_o       (irq_o)
	);

	task automatic compare(input string name, input data_t exp, input data_t got);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("FAILED %s exp %h got %h at %0t", name, exp, got, $time);
		end
	endtask

	`include "tb_bus_tasks.svh"

	task automatic write_ok(input addr_t a, input data_t d, input strb_t s, input int hold);
		resp_t r;
		axi_write(a, d, s, hold, r);
		compare("bresp", data_t'(RESP_OKAY), data_t'(r));
		model_write(a, d, s);
	endtask

	task automatic read_check(input addr_t a, input int hold);
		data_t d;
		resp_t r;
		axi_read(a, hold, d, r);
		compare("rresp", data_t'(RESP_OKAY), data_t'(r));
		compare($sformatf("rdata %h", a), model_read(a), d);
	endtask

	task automatic check_all_regs();
		for (int i = 0; i < N_REGS; i++)
			read_check(REG_LIST[i], rand_bits(2));
		compare("irq_o", data_t'(exp_irq()), data_t'(irq_o));
	endtask

	function automatic addr_t pick_gpio_reg();
		case (rand_bits(2))
			32'd0:   return A_OUT;
			32'd1:   return A_TRI;
			32'd2:   return A_IEN;
			default: return A_ISTAT;
		endcase
	endfunction

	// stamp is the cycle of the first falling edge with the flag seen high
	task automatic wait_timer_irq(output int stamp);
		@(negedge pll_clk_out);
		while (!irq_o[SLV_TMR])
			@(negedge pll_clk_out);
		stamp  = cyc;
		t_flag = 1'b1;
	endtask

	always @(posedge pll_clk_out)
	begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT_CYC)
		begin
			$display("timeout after %0d cycles, the DUT stopped answering", cyc);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial
	begin
		data_t     d;
		resp_t     r;
		strb_t     s;
		addr_t     a;
		gpio_vec_t p;
		tmr_cnt_t  load;
		int        prev;
		int        stamp;

		arst_n_i = 1'b0;
		req      = '0;
		gpio_i   = '0;
		repeat (2) @(negedge pll_clk_out);
		arst_n_i = 1'b1;
		repeat (4) @(negedge pll_clk_out); // sync release plus margin

		compare("irq_o", data_t'(exp_irq()), data_t'(irq_o));
		compare("gpio_o", '0, data_t'(gpio_o));
		compare("gpio_t_o", data_t'(m_tri), data_t'(gpio_t_o));
		check_all_regs();

		for (int i = 0; i < N_GPIO_WR; i++)
		begin
			a = pick_gpio_reg();
			d = rand_bits(32);
			s = strb_t'(rand_bits(4));
			write_ok(a, d, s, rand_bits(2));
			compare("gpio_o", data_t'(m_out), data_t'(gpio_o));
			compare("gpio_t_o", data_t'(m_tri), data_t'(gpio_t_o));
			a = pick_gpio_reg();
			read_check(a, rand_bits(2));
		end

		// pin patterns, falling edges and interrupts
		write_ok(A_IEN, rand_bits(32), 4'hF, 0);
		for (int i = 0; i < N_GPIO_IN; i++)
		begin
			p = gpio_vec_t'(rand_bits(GPIO_W));
			@(negedge pll_clk_out);
			gpio_i  = p;
			m_istat = m_istat | (m_in & ~p); // 1 to 0 only
			m_in    = p;
			repeat (4) @(negedge pll_clk_out);
			compare("irq_o", data_t'(exp_irq()), data_t'(irq_o));
			read_check(A_IN, rand_bits(2));
			read_check(A_ISTAT, rand_bits(2));
			if (rand_bits(1))
				write_ok(A_IEN, rand_bits(32), 4'hF, 0);
			d = rand_bits(32);
			s = strb_t'(rand_bits(4));
			write_ok(A_ISTAT, d, s, rand_bits(2));
			compare("irq_o", data_t'(exp_irq()), data_t'(irq_o));
		end

		// long enough for a flag read and clear inside one period
		load = tmr_cnt_t'(rand_bits(4)) + 16'd20;
		write_ok(A_LOAD, data_t'(load), 4'hF, 0);
		read_check(A_CNT, 0);
		write_ok(A_CTRL, 32'd1, 4'hF, 0);
		wait_timer_irq(prev);
		for (int k = 0; k < N_PERIODS; k++)
		begin
			read_check(A_STAT, 0);
			write_ok(A_STAT, 32'd1, 4'hF, 0);
			compare("irq_o", data_t'(exp_irq()), data_t'(irq_o));
			wait_timer_irq(stamp);
			compare("irq_o period", data_t'(load) + 32'd1, data_t'(stamp - prev));
			prev = stamp;
		end
		write_ok(A_CTRL, 32'd0, 4'hF, 0);
		write_ok(A_STAT, 32'd1, 4'hF, 0);
		write_ok(A_LOAD, rand_bits(32), 4'hF, 1); // count known again
		check_all_regs();

		for (int i = 0; i < N_UNMAP; i++)
		begin
			a = rand_bits(32);
			if (i % 3 == 0)
				a = {20'h40001, a[11:2], 2'b00};
			else if (i % 3 == 1)
				a = {20'h40003, a[11:2], 2'b00};
			else if (a[31:12] == 20'h40000 || a[31:12] == 20'h40002)
				a[31] = ~a[31];
			d = rand_bits(32);
			axi_write(a, d, 4'hF, rand_bits(2), r);
			compare($sformatf("bresp %h", a), data_t'(RESP_DECERR), data_t'(r));
			axi_read(a, rand_bits(2), d, r);
			compare($sformatf("rresp %h", a), data_t'(RESP_DECERR), data_t'(r));
		end
		check_all_regs();

		$display("checks %0d errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: periph_soc.f
+incdir+verification
logic/soc_pkg.sv
logic/sys_reset_sync.sv
logic/axi_apb_bridge.sv
logic/apb_gpio.sv
logic/apb_timer.sv
logic/periph_soc_top.sv
verification/tb_periph_soc.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_periph_soc -f periph_soc.f \
	-o tb_periph_soc > sim.log 2>&1 \
	&& ./obj_dir/tb_periph_soc >> sim.log 2>&1 \
	|| echo "TEST FAILED during build or simulation" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
